/* verilog/fpu_rnd_pkg.sv */
/* Shared types and constants of the binary32 rounding back end.
   Every module of the pipe takes them by a wildcard import. */

package fpu_rnd_pkg;

  // rounding modes, encoded as in the FPCSR
  typedef enum logic [1:0] {
    RM_NEAREST = 2'b00,
    RM_TO_ZERO = 2'b01,
    RM_TO_INFP = 2'b10,
    RM_TO_INFM = 2'b11
  } rmode_t;

  //////////////////////////////
  // producer side
  //////////////////////////////

  typedef struct packed {
    logic        rdy;
    logic        sign;
    logic        sub_zero;  // real subtraction gave exact zero
    logic [4:0]  shl;
    logic [9:0]  exp_shl;
    logic [9:0]  exp_sh0;
    logic [27:0] fract;     // carry, 24b significand, round, 2b sticky
    logic        inv;
    logic        inf;
    logic        snan;
    logic        qnan;
    logic        nan_sign;
  } add_src_t;

  typedef struct packed {
    logic        rdy;
    logic        sign;
    logic [4:0]  shr;
    logic [9:0]  exp_shr;
    logic        shl;       // mul needs at most one left step
    logic [9:0]  exp_shl;
    logic [9:0]  exp_sh0;
    logic [27:0] fract;
    logic        inv;
    logic        inf;
    logic        snan;
    logic        qnan;
    logic        nan_sign;
  } mul_src_t;

  typedef struct packed {
    logic        rdy;
    logic        sign;
    logic [23:0] int24;
    logic [4:0]  shr;
    logic [3:0]  shl;
    logic        ovf;       // magnitude already out of int32 range
    logic        snan;
  } f2i_src_t;

  //////////////////////////////
  // pipe internals
  //////////////////////////////

  typedef struct packed {
    logic        sign;
    logic [9:0]  exp;
    logic [31:0] fract;     // [23] hidden bit, [31] int carry
    logic        round;
    logic        sticky;
    logic        inv;
    logic        inf;
    logic        snan;
    logic        qnan;
    logic        nan_sign;
    logic        f2i_ovf;
    logic        is_f2i;
  } align_t;

  typedef struct packed {
    logic [23:0] fract;     // rounded, renormalised
    logic [9:0]  exp;
    logic        lost;
    logic [31:0] int32;     // two's complement
    logic        int_inv;
  } rnd_t;

  // result word is a float or an int32, depending on the op
  typedef union packed {
    struct packed {
      logic       sign;
      logic [7:0] exp;
      logic [22:0] man;
    } f;
    logic signed [31:0] i;
  } result_u;

  typedef struct packed {
    logic ovf;
    logic unf;
    logic snf;
    logic qnf;
    logic zf;
    logic ixf;
    logic ivf;
    logic inf;
  } fpcsr_t;

  localparam logic [9:0]  EXP_MAX_NORMAL = 10'd254;
  localparam logic [30:0] QNAN_BODY      = 31'h7fc0_0000;
  localparam logic [30:0] SNAN_BODY      = 31'h7fbf_ffff;
  localparam logic [30:0] INF_BODY       = 31'h7f80_0000;
  localparam logic [31:0] INT_MAX_POS    = 32'h7fff_ffff;

endpackage

/* verilog/rnd_align.sv */
/* Stage one of the rounding pipe. Picks the ready producer, aligns its
   fraction with round and sticky kept, and registers the result on adv_i. */

module rnd_align import fpu_rnd_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     adv_i,
  input  logic     flush_i,
  input  rmode_t   rmode_i,
  input  add_src_t add_i,
  input  mul_src_t mul_i,
  input  f2i_src_t f2i_i,
  output align_t   s1_o,
  output logic     s1_valid_o
);

  logic        add_sign;
  logic [34:0] fract35;
  logic [34:0] fract35_sh;
  logic [34:0] shr_mask;
  logic        addmul_carry;
  logic [4:0]  shr_src;
  logic [4:0]  shr;
  logic [4:0]  shl;
  logic        sticky_r;
  logic        sticky_l;
  logic [9:0]  exp_shr;
  logic [9:0]  exp_shl;
  logic [9:0]  exp_sh0;
  align_t      s1_d;

  // exact cancellation gives -0 only when rounding toward -inf
  assign add_sign = add_i.sub_zero ? (rmode_i == RM_TO_INFM) : add_i.sign;

  //////////////////////////////
  // producer select
  //////////////////////////////

  assign {s1_d.sign, s1_d.inv, s1_d.inf, s1_d.snan, s1_d.qnan, s1_d.nan_sign} =
    ({6{add_i.rdy}} & {add_sign, add_i.inv, add_i.inf, add_i.snan, add_i.qnan,
                       add_i.nan_sign}) |
    ({6{mul_i.rdy}} & {mul_i.sign, mul_i.inv, mul_i.inf, mul_i.snan, mul_i.qnan,
                       mul_i.nan_sign}) |
    ({6{f2i_i.rdy}} & {f2i_i.sign, 1'b0, 1'b0, f2i_i.snan, 1'b0, f2i_i.sign});

  assign fract35 = ({35{add_i.rdy}} & {7'd0, add_i.fract}) |
                   ({35{mul_i.rdy}} & {7'd0, mul_i.fract}) |
                   ({35{f2i_i.rdy}} & {8'd0, f2i_i.int24, 3'd0}); // int at bit 3 up

  // sum/product overflowed into bit 27
  assign addmul_carry = (add_i.rdy & add_i.fract[27]) | (mul_i.rdy & mul_i.fract[27]);

  assign shr_src = ({5{mul_i.rdy}} & mul_i.shr) | ({5{f2i_i.rdy}} & f2i_i.shr);
  assign shl     = ({5{add_i.rdy}} & add_i.shl) |
                   ({5{mul_i.rdy}} & {4'd0, mul_i.shl}) |
                   ({5{f2i_i.rdy}} & {1'b0, f2i_i.shl});
  assign shr     = (|shr_src) ? shr_src : {4'd0, addmul_carry}; // carry -> one step right

  //////////////////////////////
  // align and sticky
  //////////////////////////////

  assign fract35_sh = (|shr) ? (fract35 >> shr) : (fract35 << shl);

  // right shift: everything below the new round bit is sticky
  assign shr_mask = (35'd4 << shr) - 35'd1;
  assign sticky_r = |(fract35 & shr_mask);

  always_comb begin
    case (shl)
      5'd0:    sticky_l = |fract35[1:0];
      5'd1:    sticky_l = fract35[0]; // bit 1 moves up to round
      default: sticky_l = 1'b0;
    endcase
  end

  // exponent candidates, f2i has none
  assign exp_shr = {10{mul_i.rdy}} & mul_i.exp_shr;
  assign exp_shl = ({10{add_i.rdy}} & add_i.exp_shl) | ({10{mul_i.rdy}} & mul_i.exp_shl);
  assign exp_sh0 = ({10{add_i.rdy}} & add_i.exp_sh0) | ({10{mul_i.rdy}} & mul_i.exp_sh0);

  assign s1_d.exp     = (|shr_src) ? exp_shr :
                        (~(|shl))  ? (exp_sh0 + {9'd0, addmul_carry}) :
                                     exp_shl;
  assign s1_d.fract   = fract35_sh[34:3];
  assign s1_d.round   = fract35_sh[2];
  assign s1_d.sticky  = (|shr) ? sticky_r : sticky_l;
  assign s1_d.f2i_ovf = f2i_i.rdy & f2i_i.ovf;
  assign s1_d.is_f2i  = f2i_i.rdy;

  // payload holds on stall
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_o <= s1_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_o <= 1'b0;
    end else if (flush_i) begin
      s1_valid_o <= 1'b0; // flush beats advance
    end else if (adv_i) begin
      s1_valid_o <= add_i.rdy | mul_i.rdy | f2i_i.rdy;
    end
  end

endmodule

/* verilog/rnd_round.sv */
/* Rounding decision and increment for the stage-one word. Purely
   combinational, feeds the pack stage in the same cycle. */

module rnd_round import fpu_rnd_pkg::*; (
  input  rmode_t rmode_i,
  input  align_t s1_i,
  output rnd_t   rnd_o
);

  logic        guard;
  logic        lost;
  logic        rnd_up;
  logic [31:0] fract_rnd;
  logic        f32_shr;
  logic        i32_carry;

  assign guard = s1_i.fract[0]; // lsb kept, breaks ties to even
  assign lost  = s1_i.round | s1_i.sticky;

  //////////////////////////////
  // round-up decision
  //////////////////////////////

  always_comb begin
    case (rmode_i)
      RM_NEAREST: rnd_up = s1_i.round & (s1_i.sticky | guard);
      RM_TO_INFP: rnd_up = lost & ~s1_i.sign;
      RM_TO_INFM: rnd_up = lost & s1_i.sign;
      default:    rnd_up = 1'b0; // to zero truncates
    endcase
  end

  assign fract_rnd = s1_i.fract + {31'd0, rnd_up};

  //////////////////////////////
  // float path
  //////////////////////////////

  // increment rippled into bit 24
  assign f32_shr = fract_rnd[24];

  assign rnd_o.fract = f32_shr ? fract_rnd[24:1] : fract_rnd[23:0];
  assign rnd_o.exp   = s1_i.exp + {9'd0, f32_shr};
  assign rnd_o.lost  = lost;

  //////////////////////////////
  // integer path
  //////////////////////////////

  // positive value reached 2^31
  assign i32_carry = fract_rnd[31];

  assign rnd_o.int32   = (fract_rnd ^ {32{s1_i.sign}}) + {31'd0, s1_i.sign};
  assign rnd_o.int_inv = (~s1_i.sign & i32_carry) | s1_i.f2i_ovf;

endmodule

/* verilog/rnd_pack.sv */
/* Final stage. Chooses the result word and exception flags by priority
   and registers them on adv_i; flush or reset zeroes the outputs. */

module rnd_pack import fpu_rnd_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    adv_i,
  input  logic    flush_i,
  input  align_t  s1_i,
  input  logic    s1_valid_i,
  input  rnd_t    rnd_i,
  output result_u result_o,
  output logic    valid_o,
  output fpcsr_t  fpcsr_o
);

  result_u res_d;
  fpcsr_t  flg_d;
  logic    int_zero;
  logic    exp_ovf;
  logic    denorm;

  assign int_zero = ~rnd_i.int_inv & ~(|rnd_i.int32);
  assign exp_ovf  = rnd_i.exp > EXP_MAX_NORMAL;
  assign denorm   = ~rnd_i.fract[23]; // hidden bit clear, denormal or zero

  //////////////////////////////
  // result and flag select
  //////////////////////////////

  always_comb begin
    flg_d     = '0;
    // these do not depend on the result path
    flg_d.snf = s1_i.inv | (s1_i.snan & s1_i.is_f2i);
    flg_d.qnf = s1_i.qnan;
    flg_d.ivf = s1_i.inv | s1_i.snan | (rnd_i.int_inv & s1_i.is_f2i);
    if (s1_i.is_f2i) begin
      res_d.i   = rnd_i.int_inv ? (INT_MAX_POS ^ {32{s1_i.sign}}) : rnd_i.int32; // saturate
      flg_d.ixf = rnd_i.lost;
      flg_d.zf  = int_zero;
    end else if (s1_i.snan | s1_i.qnan) begin
      res_d = {s1_i.nan_sign, QNAN_BODY}; // propagated nan
    end else if (s1_i.inv) begin
      res_d = {s1_i.sign, SNAN_BODY};
    end else if (exp_ovf | s1_i.inf) begin
      res_d     = {s1_i.sign, INF_BODY};
      flg_d.ixf = rnd_i.lost | ~s1_i.inf;
      flg_d.ovf = ~s1_i.inf; // inf operand is not an overflow
      flg_d.inf = 1'b1;
    end else if (denorm) begin
      res_d.f.sign = s1_i.sign;
      res_d.f.exp  = 8'd0;
      res_d.f.man  = rnd_i.fract[22:0];
      flg_d.ixf    = rnd_i.lost;
      flg_d.unf    = rnd_i.lost; // tiny and inexact
      flg_d.zf     = ~(|rnd_i.fract);
    end else begin
      res_d.f.sign = s1_i.sign;
      res_d.f.exp  = rnd_i.exp[7:0];
      res_d.f.man  = rnd_i.fract[22:0];
      flg_d.ixf    = rnd_i.lost;
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      fpcsr_o  <= '0;
    end else if (flush_i) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      fpcsr_o  <= '0;
    end else if (adv_i) begin
      result_o <= res_d;
      valid_o  <= s1_valid_i;
      fpcsr_o  <= flg_d;
    end
  end

endmodule

/* verilog/fpu_rnd_top.sv */
/* Rounding back end of the binary32 FPU: align, round and pack.
   Two advancing cycles from producer struct to result_o. */

module fpu_rnd_top import fpu_rnd_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     adv_i,
  input  logic     flush_i,
  input  rmode_t   rmode_i,  // unregistered, used by both stages
  input  add_src_t add_i,
  input  mul_src_t mul_i,
  input  f2i_src_t f2i_i,
  output result_u  result_o,
  output logic     valid_o,
  output fpcsr_t   fpcsr_o
);

  align_t s1;
  logic   s1_valid;
  rnd_t   rnd;

  // stage one, registered
  rnd_align u_align (
    .clk        (clk),
    .rst        (rst),
    .adv_i      (adv_i),
    .flush_i    (flush_i),
    .rmode_i    (rmode_i),
    .add_i      (add_i),
    .mul_i      (mul_i),
    .f2i_i      (f2i_i),
    .s1_o       (s1),
    .s1_valid_o (s1_valid)
  );

  // comb, between the two registers
  rnd_round u_round (
    .rmode_i (rmode_i),
    .s1_i    (s1),
    .rnd_o   (rnd)
  );

  rnd_pack u_pack (
    .clk        (clk),
    .rst        (rst),
    .adv_i      (adv_i),
    .flush_i    (flush_i),
    .s1_i       (s1),
    .s1_valid_i (s1_valid),
    .rnd_i      (rnd),
    .result_o   (result_o),
    .valid_o    (valid_o),
    .fpcsr_o    (fpcsr_o)
  );

endmodule

/* tb/fpu_rnd_props.sv */
/* Concurrent checks on the rounding back end ports.
   Attached to fpu_rnd_top by the bind at the bottom. */

module fpu_rnd_props import fpu_rnd_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     adv_i,
  input logic     flush_i,
  input add_src_t add_i,
  input mul_src_t mul_i,
  input f2i_src_t f2i_i,
  input result_u  result_o,
  input logic     valid_o,
  input fpcsr_t   fpcsr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  a_reset_clears_valid: assert property (@(posedge clk) rst |=> !valid_o)
    else $error("valid_o high in the cycle after reset");

  // producers never collide
  a_one_producer: assert property (@(posedge clk)
    $onehot0({add_i.rdy, mul_i.rdy, f2i_i.rdy}))
    else $error("more than one producer ready");

  a_stall_holds: assert property (@(posedge clk) disable iff (rst)
    (!adv_i && !flush_i) |=> ($stable(result_o) && $stable(valid_o) && $stable(fpcsr_o)))
    else $error("outputs moved while stalled");

  a_inf_not_zero: assert property (@(posedge clk) !(fpcsr_o.inf && fpcsr_o.zf))
    else $error("inf and zf flags set together");

endmodule

bind fpu_rnd_top fpu_rnd_props u_props (.*);

/* tb/fpu_rnd_tb.sv */
/* Testbench for the rounding back end. Applies a table of producer structs
   with hand-worked results, then checks stall, random hold and flush. */

module fpu_rnd_tb import fpu_rnd_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 20; // cycles for valid_o

  typedef struct packed {
    rmode_t   rmode;
    add_src_t add;
    mul_src_t mul;
    f2i_src_t f2i;
    result_u  res;
    fpcsr_t   flg;    // ovf unf snf qnf zf ixf ivf inf
  } row_t;

  logic     clk;
  logic     rst;
  logic     adv;
  logic     flush;
  rmode_t   rmode;
  add_src_t add_src;
  mul_src_t mul_src;
  f2i_src_t f2i_src;
  result_u  result;
  logic     valid;
  fpcsr_t   fpcsr;
  row_t     rows[$];
  integer   seed = 32'h432d_5098;
  int       hold;

  fpu_rnd_top u_fpu_rnd_top (
    .clk(clk), .rst(rst), .adv_i(adv), .flush_i(flush), .rmode_i(rmode),
    .add_i(add_src), .mul_i(mul_src), .f2i_i(f2i_src),
    .result_o(result), .valid_o(valid), .fpcsr_o(fpcsr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // stimulus builders
  //////////////////////////////

  // spec is {inv, inf, snan, qnan, nan_sign}
  function automatic add_src_t add_stim(input logic sign, input logic sub_zero,
      input logic [9:0] exp, input logic [27:0] fract, input logic [4:0] spec);
    add_src_t s;
    s = '0;
    s.rdy = 1'b1;
    s.sign = sign;
    s.sub_zero = sub_zero;
    s.exp_sh0 = exp; // no left shift in these rows
    s.fract = fract;
    {s.inv, s.inf, s.snan, s.qnan, s.nan_sign} = spec;
    return s;
  endfunction

  function automatic mul_src_t mul_stim(input logic sign, input logic [4:0] shr,
      input logic shl, input logic [9:0] exp, input logic [27:0] fract);
    mul_src_t s;
    s = '0;
    s.rdy = 1'b1;
    s.sign = sign;
    s.shr = shr;
    s.shl = shl;
    // exponent only on the field the shift selects
    if (shr != 5'd0) begin
      s.exp_shr = exp;
    end else if (shl) begin
      s.exp_shl = exp;
    end else begin
      s.exp_sh0 = exp;
    end
    s.fract = fract;
    return s;
  endfunction

  function automatic f2i_src_t f2i_stim(input logic sign, input logic [23:0] int24,
      input logic [4:0] shr, input logic ovf);
    f2i_src_t s;
    s = '0;
    s.rdy = 1'b1;
    s.sign = sign;
    s.int24 = int24;
    s.shr = shr;
    s.ovf = ovf;
    return s;
  endfunction

  task automatic push_row(input rmode_t rm, input add_src_t a, input mul_src_t m,
      input f2i_src_t f, input result_u res, input fpcsr_t flg);
    rows.push_back({rm, a, m, f, res, flg});
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input result_u got, input result_u want, input string what);
    if (got !== want) begin
      $display("[FAIL] %t: %s result %h, expected %h", $time, what, got, want);
      abort_run();
    end
  endtask

  task automatic check_flags(input fpcsr_t got, input fpcsr_t want, input string what);
    if (got !== want) begin
      $display("[FAIL] %t: %s flags %b, expected %b", $time, what, got, want);
      abort_run();
    end
  endtask

  task automatic check_valid(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("[FAIL] %t: %s valid_o %b, expected %b", $time, what, got, want);
      abort_run();
    end
  endtask

  //////////////////////////////
  // drive and wait
  //////////////////////////////

  task automatic drive_row(input row_t r); // called on a falling edge
    rmode   = r.rmode; // held until the next row for stage two
    add_src = r.add;
    mul_src = r.mul;
    f2i_src = r.f2i;
  endtask

  task automatic idle_sources();
    add_src = '0;
    mul_src = '0;
    f2i_src = '0;
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (valid !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        $display("timeout: valid_o did not rise within %0d cycles", WAIT_LIMIT);
        abort_run();
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic run_row(input row_t r, input string what);
    drive_row(r);
    @(negedge clk);
    idle_sources();
    wait_valid();
    check_result(result, r.res, what);
    check_flags(fpcsr, r.flg, what);
    @(negedge clk); // drain until valid_o drops
  endtask

  task automatic hold_outputs(input int cycles, input string what);
    result_u snap_res;
    fpcsr_t  snap_flg;
    logic    snap_vld;
    snap_res = result;
    snap_flg = fpcsr;
    snap_vld = valid;
    repeat (cycles) begin
      @(negedge clk);
      check_result(result, snap_res, what);
      check_flags(fpcsr, snap_flg, what);
      check_valid(valid, snap_vld, what);
    end
  endtask

  //////////////////////////////
  // table and sequence
  //////////////////////////////

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst = 1'b1;
    adv = 1'b0;
    flush = 1'b0;
    rmode = RM_NEAREST;
    idle_sources();

    // nearest-even on add with ties and carries
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd127, 28'h400_0004, 5'b0), '0, '0,
             32'h3f80_0000, 8'h04);
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd127, 28'h400_000c, 5'b0), '0, '0,
             32'h3f80_0002, 8'h04);
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd127, 28'h400_0005, 5'b0), '0, '0,
             32'h3f80_0001, 8'h04);
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd127, 28'h800_0018, 5'b0), '0, '0,
             32'h4000_0002, 8'h04);
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd127, 28'h7ff_fffd, 5'b0), '0, '0,
             32'h4000_0000, 8'h04);
    push_row(RM_NEAREST, add_stim(1'b1, 1'b0, 10'd130, 28'h500_0000, 5'b0), '0, '0,
             32'hc120_0000, 8'h00);
    // mul with shr 3 and sticky only gives a denormal
    push_row(RM_NEAREST, '0, mul_stim(1'b0, 5'd3, 1'b0, 10'd0, 28'h400_0008), '0,
             32'h0010_0000, 8'h44);
    push_row(RM_TO_INFP, '0, mul_stim(1'b0, 5'd3, 1'b0, 10'd0, 28'h400_0008), '0,
             32'h0010_0001, 8'h44);
    push_row(RM_TO_INFM, '0, mul_stim(1'b1, 5'd3, 1'b0, 10'd0, 28'h400_0008), '0,
             32'h8010_0001, 8'h44);
    push_row(RM_TO_ZERO, '0, mul_stim(1'b1, 5'd3, 1'b0, 10'd0, 28'h400_0008), '0,
             32'h8010_0000, 8'h44);
    push_row(RM_TO_INFP, '0, mul_stim(1'b1, 5'd3, 1'b0, 10'd0, 28'h400_0008), '0,
             32'h8010_0000, 8'h44);
    push_row(RM_NEAREST, '0, mul_stim(1'b0, 5'd0, 1'b1, 10'd126, 28'h200_0003), '0,
             32'h3f00_0001, 8'h04);
    // producer shr 1 over the carry takes exp_shr
    push_row(RM_NEAREST, '0, mul_stim(1'b0, 5'd1, 1'b0, 10'd130, 28'h800_000c), '0,
             32'h4100_0001, 8'h04);
    // specials
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd0, 28'h0, 5'b00011), '0, '0,
             32'hffc0_0000, 8'h10);
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd0, 28'h0, 5'b10000), '0, '0,
             32'h7fbf_ffff, 8'h22);
    push_row(RM_NEAREST, add_stim(1'b1, 1'b0, 10'd255, 28'h0, 5'b01000), '0, '0,
             32'hff80_0000, 8'h01);
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd255, 28'h400_0000, 5'b0), '0, '0,
             32'h7f80_0000, 8'h85);
    // small results
    push_row(RM_NEAREST, add_stim(1'b0, 1'b0, 10'd0, 28'h000_008c, 5'b0), '0, '0,
             32'h0000_0012, 8'h44);
    push_row(RM_TO_INFM, add_stim(1'b0, 1'b1, 10'd0, 28'h0, 5'b0), '0, '0,
             32'h8000_0000, 8'h08);
    // float to int
    push_row(RM_NEAREST, '0, '0, f2i_stim(1'b1, 24'd1000, 5'd0, 1'b0), 32'hffff_fc18, 8'h00);
    push_row(RM_NEAREST, '0, '0, f2i_stim(1'b0, 24'h3eb, 5'd2, 1'b0), 32'h0000_00fb, 8'h04);
    push_row(RM_NEAREST, '0, '0, f2i_stim(1'b0, 24'd0, 5'd0, 1'b1), 32'h7fff_ffff, 8'h02);
    push_row(RM_NEAREST, '0, '0, f2i_stim(1'b1, 24'd0, 5'd0, 1'b1), 32'h8000_0000, 8'h02);
    push_row(RM_NEAREST, '0, '0, f2i_stim(1'b0, 24'd0, 5'd0, 1'b0), 32'h0000_0000, 8'h08);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    adv = 1'b1;

    for (int k = 0; k < rows.size(); k++) begin
      run_row(rows[k], $sformatf("row %0d", k));
    end

    // stall of random length with the item in stage one
    hold = 2 + ($unsigned($random(seed)) % 6);
    drive_row(rows[2]);
    @(negedge clk);
    idle_sources();
    adv = 1'b0;
    hold_outputs(hold, "stall in stage one");
    adv = 1'b1;
    wait_valid();
    check_result(result, rows[2].res, "after stall");
    check_flags(fpcsr, rows[2].flg, "after stall");
    adv = 1'b0; // valid_o must stay up
    hold_outputs(hold, "stall at output");

    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    check_valid(valid, 1'b0, "flush at output");
    check_result(result, '0, "flush at output");
    check_flags(fpcsr, '0, "flush at output");

    // flush beats advance with an item in stage one
    adv = 1'b1;
    drive_row(rows[0]);
    @(negedge clk);
    flush = 1'b1; // producer still ready so the flush must win
    @(negedge clk);
    flush = 1'b0;
    idle_sources();
    repeat (3) begin
      @(negedge clk);
      check_valid(valid, 1'b0, "flush in stage one");
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* fpu_rnd_top.f */
verilog/fpu_rnd_pkg.sv
verilog/rnd_align.sv
verilog/rnd_round.sv
verilog/rnd_pack.sv
verilog/fpu_rnd_top.sv
tb/fpu_rnd_props.sv
tb/fpu_rnd_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fpu_rnd_tb -f fpu_rnd_top.f

out=$(./obj_dir/Vfpu_rnd_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS'; then
  exit 0
fi
exit 1
